//--- design/legv8_defines.svh
`ifndef LEGV8_DEFINES_SVH
`define LEGV8_DEFINES_SVH

`define LEGV8_XLEN 64 // Datapath width
`define LEGV8_CW_W 33 // Control word width
`define LEGV8_RA_W 5  // Register index width

// 11-bit opcodes of the R and D formats
`define LEGV8_OP_ADD   11'b10001011000
`define LEGV8_OP_SUB   11'b11001011000
`define LEGV8_OP_AND   11'b10001010000
`define LEGV8_OP_ORR   11'b10101010000
`define LEGV8_OP_EOR   11'b11001010000
`define LEGV8_OP_ADDS  11'b10101011000
`define LEGV8_OP_SUBS  11'b11101011000
`define LEGV8_OP_LSL   11'b11010011011
`define LEGV8_OP_LSR   11'b11010011010
`define LEGV8_OP_LDUR  11'b11111000010
`define LEGV8_OP_STUR  11'b11111000000
`define LEGV8_OP_BR    11'b11010110000
`define LEGV8_OP_ADDI  10'b1001000100   // I format
`define LEGV8_OP_SUBI  10'b1101000100
`define LEGV8_OP_MOVZ  9'b110100101     // IW format
`define LEGV8_OP_MOVK  9'b111100101
`define LEGV8_OP_CBZ   8'b10110100      // CB format
`define LEGV8_OP_BCOND 8'b01010100
`define LEGV8_OP_B     6'b000101        // B format

// Condition codes in the Rt field of B.cond
`define LEGV8_COND_EQ 5'h00
`define LEGV8_COND_NE 5'h01

`define LEGV8_ST_0 2'b00 // Micro-states
`define LEGV8_ST_1 2'b01

`define LEGV8_PC_HOLD 2'b00 // PC function select
`define LEGV8_PC_INC4 2'b01
`define LEGV8_PC_ADDK 2'b10
`define LEGV8_PC_LOAD 2'b11

// ALU operation, upper 3 bits of the function select
`define LEGV8_FS_AND 3'b000
`define LEGV8_FS_OR  3'b001
`define LEGV8_FS_ADD 3'b010
`define LEGV8_FS_XOR 3'b011
`define LEGV8_FS_LSL 3'b100
`define LEGV8_FS_LSR 3'b101

`endif

//--- design/legv8_pkg.sv
`default_nettype none
`include "legv8_defines.svh"

package legv8_pkg;

    typedef logic [`LEGV8_RA_W-1:0] reg_addr_t; // X0..X31

    // Micro-op for one cycle, MSB first
    typedef struct packed {
        logic       alu_en;     // ALU drives databus
        logic       alu_bs;     // ALU B takes K
        logic [4:0] alu_fs;     // {op, invert B, invert A}
        logic       rf_b_en;    // Port B drives databus
        reg_addr_t  rf_sa;
        reg_addr_t  rf_sb;
        reg_addr_t  rf_da;      // Write address
        logic       rf_w;
        logic       ram_en;     // Memory drives databus, also read strobe
        logic       ram_w;
        logic       pc_en;      // PC drives databus
        logic [1:0] pc_fs;
        logic       pc_is;      // 0 K, 1 databus
        logic       status_ld;
        logic [1:0] next_state;
    } control_word_t;

    typedef struct packed {
        logic [10:0] opcode;
        reg_addr_t   rm;
        logic [5:0]  shamt;
        reg_addr_t   rn;
        reg_addr_t   rd;
    } r_fmt_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;  // Zero extended
        reg_addr_t   rn;
        reg_addr_t   rd;
    } i_fmt_t;

    typedef struct packed {
        logic [10:0] opcode;
        logic [8:0]  addr9;  // Signed byte offset
        logic [1:0]  op2;
        reg_addr_t   rn;
        reg_addr_t   rt;
    } d_fmt_t;

    typedef struct packed {
        logic [8:0]  opcode;
        logic [1:0]  hw;     // 16-bit lane
        logic [15:0] imm16;
        reg_addr_t   rd;
    } iw_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] addr26; // Word offset
    } b_fmt_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [18:0] addr19; // Word offset
        reg_addr_t   rt;     // Register or condition
    } cb_fmt_t;

    // One fetched word, one view per format
    typedef union packed {
        r_fmt_t  r_fmt;
        i_fmt_t  i_fmt;
        d_fmt_t  d_fmt;
        iw_fmt_t iw_fmt;
        b_fmt_t  b_fmt;
        cb_fmt_t cb_fmt;
    } instr_u;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
        logic zero_now; // Live ALU zero for CBZ
    } status_t;

endpackage

`default_nettype wire

//--- design/wide_imm_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "legv8_defines.svh"

// MOVZ in one cycle, MOVK as AND then OR
module wide_imm_decoder
    import legv8_pkg::*;
(
    input  wire instr_u             instr,
    input  wire logic [1:0]         state,
    input  wire status_t            status,
    output control_word_t           cw,
    output logic [`LEGV8_XLEN-1:0]  k
);

    logic                   is_movk;
    logic                   and_step;  // First MOVK cycle
    logic [5:0]             lane_sh;   // hw * 16
    logic [`LEGV8_XLEN-1:0] lane_imm;
    logic [`LEGV8_XLEN-1:0] lane_mask;

    assign is_movk  = (instr.iw_fmt.opcode == `LEGV8_OP_MOVK);
    assign and_step = is_movk && (state == `LEGV8_ST_0);
    assign lane_sh  = {instr.iw_fmt.hw, 4'b0000};

    // Immediate moved into its lane, other lanes zero
    assign lane_imm  = {{(`LEGV8_XLEN-16){1'b0}}, instr.iw_fmt.imm16} << lane_sh;
    // Zeros only in the selected lane
    assign lane_mask = ~({{(`LEGV8_XLEN-16){1'b0}}, 16'hffff} << lane_sh);

    assign k = and_step ? lane_mask : lane_imm;

    always_comb begin
        cw            = control_word_t'({`LEGV8_CW_W{1'b0}});
        cw.alu_en     = 1'b1;   // Result goes to Rd over the bus
        cw.alu_bs     = 1'b1;   // B is K
        cw.alu_fs     = and_step ? {`LEGV8_FS_AND, 2'b00} : {`LEGV8_FS_OR, 2'b00};
        // MOVK keeps the old Rd, MOVZ starts from zero
        cw.rf_sa      = is_movk ? instr.iw_fmt.rd : 5'd31;
        cw.rf_sb      = 5'd31;
        cw.rf_da      = instr.iw_fmt.rd;
        cw.rf_w       = 1'b1;
        cw.pc_fs      = and_step ? `LEGV8_PC_HOLD : `LEGV8_PC_INC4;
        cw.next_state = and_step ? `LEGV8_ST_1 : `LEGV8_ST_0;
    end

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "legv8_defines.svh"

module instr_decoder
    import legv8_pkg::*;
(
    input  wire instr_u             instr,
    input  wire logic [1:0]         state,
    input  wire status_t            status,
    output control_word_t           cw,
    output logic [`LEGV8_XLEN-1:0]  k
);

    control_word_t          wide_cw;
    logic [`LEGV8_XLEN-1:0] wide_k;
    logic [`LEGV8_XLEN-1:0] d_off;     // D-format byte offset
    logic [`LEGV8_XLEN-1:0] b_off;     // B target offset
    logic [`LEGV8_XLEN-1:0] cb_off;    // CB target offset
    logic [4:0]             r_fs;
    logic                   is_wide, is_r, is_shift, is_flag, is_i;
    logic                   is_ldur, is_stur, is_br, is_b, is_cbz, is_bcond;
    logic                   take_cond; // B.cond outcome

    wide_imm_decoder wide_i (
        .instr  (instr),
        .state  (state),
        .status (status),
        .cw     (wide_cw),
        .k      (wide_k)
    );

    // Each format compares its own opcode field
    assign is_wide  = instr.iw_fmt.opcode inside {`LEGV8_OP_MOVZ, `LEGV8_OP_MOVK};
    assign is_shift = instr.r_fmt.opcode inside {`LEGV8_OP_LSL, `LEGV8_OP_LSR};
    assign is_flag  = instr.r_fmt.opcode inside {`LEGV8_OP_ADDS, `LEGV8_OP_SUBS};
    assign is_r     = is_shift || is_flag || (instr.r_fmt.opcode inside
                      {`LEGV8_OP_ADD, `LEGV8_OP_SUB, `LEGV8_OP_AND, `LEGV8_OP_ORR, `LEGV8_OP_EOR});
    assign is_i     = instr.i_fmt.opcode inside {`LEGV8_OP_ADDI, `LEGV8_OP_SUBI};
    assign is_ldur  = (instr.d_fmt.opcode == `LEGV8_OP_LDUR);
    assign is_stur  = (instr.d_fmt.opcode == `LEGV8_OP_STUR);
    assign is_br    = (instr.r_fmt.opcode == `LEGV8_OP_BR);
    assign is_b     = (instr.b_fmt.opcode == `LEGV8_OP_B);
    assign is_cbz   = (instr.cb_fmt.opcode == `LEGV8_OP_CBZ);
    assign is_bcond = (instr.cb_fmt.opcode == `LEGV8_OP_BCOND);

    // Sign extension, branch offsets in words
    assign d_off  = {{(`LEGV8_XLEN-9){instr.d_fmt.addr9[8]}}, instr.d_fmt.addr9};
    assign b_off  = {{(`LEGV8_XLEN-28){instr.b_fmt.addr26[25]}}, instr.b_fmt.addr26, 2'b00};
    assign cb_off = {{(`LEGV8_XLEN-21){instr.cb_fmt.addr19[18]}}, instr.cb_fmt.addr19, 2'b00};

    // Only EQ and NE exist
    assign take_cond = ((instr.cb_fmt.rt == `LEGV8_COND_EQ) && status.z) ||
                       ((instr.cb_fmt.rt == `LEGV8_COND_NE) && !status.z);

    always_comb begin
        case (instr.r_fmt.opcode)
            `LEGV8_OP_SUB, `LEGV8_OP_SUBS: r_fs = {`LEGV8_FS_ADD, 2'b10}; // A + ~B + 1
            `LEGV8_OP_AND:                 r_fs = {`LEGV8_FS_AND, 2'b00};
            `LEGV8_OP_ORR:                 r_fs = {`LEGV8_FS_OR,  2'b00};
            `LEGV8_OP_EOR:                 r_fs = {`LEGV8_FS_XOR, 2'b00};
            `LEGV8_OP_LSL:                 r_fs = {`LEGV8_FS_LSL, 2'b00};
            `LEGV8_OP_LSR:                 r_fs = {`LEGV8_FS_LSR, 2'b00};
            default:                       r_fs = {`LEGV8_FS_ADD, 2'b00};
        endcase
    end

    always_comb begin
        cw = control_word_t'({`LEGV8_CW_W{1'b0}}); // Idle word, PC holds, no writes
        k  = '0;
        if (is_wide) begin
            cw = wide_cw;
            k  = wide_k;
        end else if (is_r) begin
            cw.alu_en    = 1'b1;
            cw.alu_bs    = is_shift;   // Shift amount from K
            cw.alu_fs    = r_fs;
            cw.rf_sa     = instr.r_fmt.rn;
            cw.rf_sb     = instr.r_fmt.rm;
            cw.rf_da     = instr.r_fmt.rd;
            cw.rf_w      = 1'b1;
            cw.pc_fs     = `LEGV8_PC_INC4;
            cw.status_ld = is_flag;
            k            = {{(`LEGV8_XLEN-6){1'b0}}, instr.r_fmt.shamt};
        end else if (is_i) begin
            cw.alu_en = 1'b1;
            cw.alu_bs = 1'b1;
            cw.alu_fs = (instr.i_fmt.opcode == `LEGV8_OP_SUBI) ?
                        {`LEGV8_FS_ADD, 2'b10} : {`LEGV8_FS_ADD, 2'b00};
            cw.rf_sa  = instr.i_fmt.rn;
            cw.rf_da  = instr.i_fmt.rd;
            cw.rf_w   = 1'b1;
            cw.pc_fs  = `LEGV8_PC_INC4;
            k         = {{(`LEGV8_XLEN-12){1'b0}}, instr.i_fmt.imm12};
        end else if (is_ldur || is_stur) begin
            // ALU forms the address for both
            cw.alu_bs = 1'b1;
            cw.alu_fs = {`LEGV8_FS_ADD, 2'b00};
            cw.rf_sa  = instr.d_fmt.rn;
            cw.rf_sb  = instr.d_fmt.rt;  // Store data
            cw.rf_da  = instr.d_fmt.rt;
            cw.rf_w   = is_ldur;         // Load data arrives over the bus
            cw.ram_en = is_ldur;
            cw.ram_w  = is_stur;
            cw.pc_fs  = `LEGV8_PC_INC4;
            k         = d_off;
        end else if (is_br) begin
            cw.rf_b_en = 1'b1;           // Rn onto the bus
            cw.rf_sb   = instr.r_fmt.rn;
            cw.pc_fs   = `LEGV8_PC_LOAD;
            cw.pc_is   = 1'b1;
        end else if (is_b) begin
            cw.pc_fs = `LEGV8_PC_ADDK;
            k        = b_off;
        end else if (is_cbz) begin
            // Rt OR X31 through the ALU drives zero_now
            cw.alu_fs = {`LEGV8_FS_OR, 2'b00};
            cw.rf_sa  = instr.cb_fmt.rt;
            cw.rf_sb  = 5'd31;
            cw.pc_fs  = status.zero_now ? `LEGV8_PC_ADDK : `LEGV8_PC_INC4;
            k         = cb_off;
        end else if (is_bcond) begin
            cw.pc_fs = take_cond ? `LEGV8_PC_ADDK : `LEGV8_PC_INC4;
            k        = cb_off;
        end
    end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "legv8_defines.svh"

module alu
    import legv8_pkg::*;
(
    input  wire logic [`LEGV8_XLEN-1:0] a,
    input  wire logic [`LEGV8_XLEN-1:0] b,
    input  wire logic [4:0]             fs,     // {op, invert B, invert A}
    output logic [`LEGV8_XLEN-1:0]      y,
    output status_t                     flags
);

    logic [`LEGV8_XLEN-1:0] a_in;
    logic [`LEGV8_XLEN-1:0] b_in;
    logic [`LEGV8_XLEN:0]   sum;     // Carry in the top bit

    assign a_in = fs[0] ? ~a : a;
    assign b_in = fs[1] ? ~b : b;

    // Inverting B also adds one, so A - B is A + ~B + 1
    assign sum = {1'b0, a_in} + {1'b0, b_in} + {{`LEGV8_XLEN{1'b0}}, fs[1]};

    always_comb begin
        case (fs[4:2])
            `LEGV8_FS_AND: y = a_in & b_in;
            `LEGV8_FS_OR:  y = a_in | b_in;
            `LEGV8_FS_ADD: y = sum[`LEGV8_XLEN-1:0];
            `LEGV8_FS_XOR: y = a_in ^ b_in;
            `LEGV8_FS_LSL: y = a_in << b_in[5:0];  // Amount in low 6 bits
            `LEGV8_FS_LSR: y = a_in >> b_in[5:0];
            default:       y = '0;
        endcase
    end

    // N Z C V from the adder
    assign flags = '{
        n:        sum[`LEGV8_XLEN-1],
        z:        (sum[`LEGV8_XLEN-1:0] == '0),
        c:        sum[`LEGV8_XLEN],
        v:        (a_in[`LEGV8_XLEN-1] == b_in[`LEGV8_XLEN-1]) &&
                  (sum[`LEGV8_XLEN-1] != a_in[`LEGV8_XLEN-1]),
        zero_now: (y == '0)  // Whatever op is selected
    };

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import legv8_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire reg_addr_t   sa,
    input  wire reg_addr_t   sb,
    input  wire reg_addr_t   da,
    input  wire logic [63:0] wd,   // From the databus
    input  wire logic        w,
    output logic [63:0]      qa,
    output logic [63:0]      qb
);

    logic [63:0] regs [0:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w && (da != 5'd31)) begin // XZR never written
            regs[da] <= wd;
        end
    end

    // X31 reads as zero
    assign qa = (sa == 5'd31) ? '0 : regs[sa];
    assign qb = (sb == 5'd31) ? '0 : regs[sb];

endmodule

`default_nettype wire

//--- design/legv8_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "legv8_defines.svh"

module legv8_cpu
    import legv8_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    output logic [`LEGV8_XLEN-1:0]      imem_addr,
    input  wire instr_u                 imem_data,
    output logic [`LEGV8_XLEN-1:0]      dmem_addr,
    output logic [`LEGV8_XLEN-1:0]      dmem_wdata,
    output logic                        dmem_we,
    output logic                        dmem_re,
    input  wire logic [`LEGV8_XLEN-1:0] dmem_rdata,
    output logic                        halted
);

    logic [`LEGV8_XLEN-1:0] pc_q;
    logic [`LEGV8_XLEN-1:0] pc_in;    // K or databus
    logic [`LEGV8_XLEN-1:0] pc_next;
    logic [1:0]             state_q;
    logic [3:0]             nzcv_q;   // Saved flags
    status_t                status;
    status_t                alu_flags;
    control_word_t          cw;
    logic [`LEGV8_XLEN-1:0] k;
    logic [`LEGV8_XLEN-1:0] qa, qb;
    logic [`LEGV8_XLEN-1:0] alu_b, alu_y;
    logic [`LEGV8_XLEN-1:0] bus;      // Shared databus
    logic                   is_halt;

    instr_decoder dec_i (
        .instr  (imem_data),
        .state  (state_q),
        .status (status),
        .cw     (cw),
        .k      (k)
    );

    reg_file rf_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sa    (cw.rf_sa),
        .sb    (cw.rf_sb),
        .da    (cw.rf_da),
        .wd    (bus),
        .w     (cw.rf_w),
        .qa    (qa),
        .qb    (qb)
    );

    assign alu_b = cw.alu_bs ? k : qb;

    alu alu_i (
        .a     (qa),
        .b     (alu_b),
        .fs    (cw.alu_fs),
        .y     (alu_y),
        .flags (alu_flags)
    );

    // Stored flags plus live zero for CBZ
    assign status = '{n: nzcv_q[3], z: nzcv_q[2], c: nzcv_q[1], v: nzcv_q[0],
                      zero_now: alu_flags.zero_now};

    always_comb begin
        if (cw.alu_en) begin
            bus = alu_y;
        end else if (cw.rf_b_en) begin
            bus = qb;
        end else if (cw.ram_en) begin
            bus = dmem_rdata;
        end else if (cw.pc_en) begin
            bus = pc_q;
        end else begin
            bus = '0;  // Nobody drives
        end
    end

    assign pc_in = cw.pc_is ? bus : k;

    always_comb begin
        case (cw.pc_fs)
            `LEGV8_PC_HOLD: pc_next = pc_q;           // HALT and MOVK first step
            `LEGV8_PC_INC4: pc_next = pc_q + `LEGV8_XLEN'd4;
            `LEGV8_PC_ADDK: pc_next = pc_q + pc_in;   // Relative branch
            `LEGV8_PC_LOAD: pc_next = pc_in;          // BR
        endcase
    end

    assign is_halt = (imem_data == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= '0;
            state_q <= `LEGV8_ST_0;
            nzcv_q  <= '0;
            halted  <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            state_q <= cw.next_state;
            if (cw.status_ld) begin
                nzcv_q <= {alu_flags.n, alu_flags.z, alu_flags.c, alu_flags.v};
            end
            if (is_halt) begin
                halted <= 1'b1;  // Sticky until reset
            end
        end
    end

    assign imem_addr  = pc_q;
    assign dmem_addr  = alu_y;  // Rn + offset
    assign dmem_wdata = qb;
    assign dmem_we    = cw.ram_w;
    assign dmem_re    = cw.ram_en;

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock, reset low for the first cycles
module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;  // Released just after an edge
    end

endmodule

`default_nettype wire

//--- tb/tb_legv8_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "legv8_defines.svh"

module tb_legv8_cpu;

    localparam int         IMEM_WORDS   = 1024;
    localparam int         DMEM_WORDS   = 256;
    localparam int         HALT_TIMEOUT = 4000;   // Cycles
    localparam logic [4:0] XBASE        = 5'd28;  // Store base register
    localparam logic [4:0] XT           = 5'd20;  // Taken marker
    localparam logic [4:0] XNT          = 5'd21;  // Not-taken marker

    logic        clk, rst_n;
    logic [63:0] imem_addr, dmem_addr, dmem_wdata, dmem_rdata;
    logic [31:0] imem_data;
    logic        dmem_we, dmem_re, halted;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [63:0] dmem [0:DMEM_WORDS-1];
    logic [63:0] regs_m [0:31];           // Predicted registers
    logic [63:0] mem_m [0:DMEM_WORDS-1];  // Predicted memory
    logic [63:0] exp_addr [$];            // Predicted stores, in order
    logic [63:0] exp_data [$];
    logic [63:0] load_addr;               // Address of the single LDUR
    logic        z_m;                     // Predicted Z flag
    logic        wr_pend;
    logic [63:0] wr_addr, wr_data;
    int          pc_w, slot;              // Next word to emit, next store slot
    int          seed = 32'h76b81107;
    int          val_errs, other_errs, stores_seen, loads_seen;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(10)) clk_i (.clk(clk), .rst_n(rst_n));

    legv8_cpu dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    // Past the end reads as HALT
    assign imem_data  = (imem_addr < 64'(IMEM_WORDS * 4)) ? imem[imem_addr[11:2]] : 32'h0;
    assign dmem_rdata = dmem[dmem_addr[10:3]];

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            $display("error %s got %h expected %h", name, got, want);
            val_errs++;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (dmem_we) begin
                stores_seen++;
                assert (exp_addr.size() != 0) else begin
                    $display("store to address %h was not predicted", dmem_addr);
                    other_errs++;
                end
                if (exp_addr.size() != 0) begin
                    check_value("dmem_addr", dmem_addr, exp_addr.pop_front());
                    check_value("dmem_wdata", dmem_wdata, exp_data.pop_front());
                end
                wr_pend = 1'b1;
                wr_addr = dmem_addr;
                wr_data = dmem_wdata;
            end
            if (dmem_re) begin
                loads_seen++;
                check_value("dmem_addr", dmem_addr, load_addr);
            end
        end else if ($time > 0) begin  // No real clock edge at time 0
            check_value("imem_addr", imem_addr, 64'h0);
            check_value("halted", 64'(halted), 64'h0);
            check_value("dmem_we", 64'(dmem_we), 64'h0);
        end
    end

    always @(posedge clk) begin
        if (wr_pend) begin
            #1;  // Memory updates just after the edge
            dmem[wr_addr[10:3]] = wr_data;
            wr_pend = 1'b0;
        end
    end

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic put(input logic [31:0] word);
        imem[pc_w] = word;
        pc_w++;
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [63:0] v);
        if (rd != 5'd31) regs_m[rd] = v;  // XZR stays zero
    endtask

    task automatic movz(input logic [4:0] rd, input logic [1:0] hw, input logic [15:0] imm);
        put({`LEGV8_OP_MOVZ, hw, imm, rd});
        write_reg(rd, {48'h0, imm} << (16 * hw));
    endtask

    task automatic movk(input logic [4:0] rd, input logic [1:0] hw, input logic [15:0] imm);
        logic [63:0] lane;
        lane = 64'hffff << (16 * hw);
        put({`LEGV8_OP_MOVK, hw, imm, rd});
        write_reg(rd, (regs_m[rd] & ~lane) | ({48'h0, imm} << (16 * hw)));
    endtask

    // One MOVZ, three MOVK, lanes shuffled
    task automatic load_const(input logic [4:0] rd, input logic [63:0] v);
        int order [4];
        int j, t;
        for (int i = 0; i < 4; i++) order[i] = i;
        for (int i = 3; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        movz(rd, 2'(order[0]), v[16 * order[0] +: 16]);
        for (int i = 1; i < 4; i++) movk(rd, 2'(order[i]), v[16 * order[i] +: 16]);
    endtask

    task automatic r_op(input logic [10:0] op, input logic [4:0] rd, rn, rm,
                        input logic [5:0] shamt);
        logic [63:0] a, b, res;
        a = regs_m[rn];
        b = regs_m[rm];
        case (op)
            `LEGV8_OP_ADD, `LEGV8_OP_ADDS: res = a + b;  // Wraps at 64 bits
            `LEGV8_OP_SUB, `LEGV8_OP_SUBS: res = a - b;
            `LEGV8_OP_AND:                 res = a & b;
            `LEGV8_OP_ORR:                 res = a | b;
            `LEGV8_OP_EOR:                 res = a ^ b;
            `LEGV8_OP_LSL:                 res = a << shamt;
            default:                       res = a >> shamt;  // LSR
        endcase
        if (op == `LEGV8_OP_ADDS || op == `LEGV8_OP_SUBS) z_m = (res == 64'h0);
        put({op, rm, shamt, rn, rd});
        write_reg(rd, res);
    endtask

    task automatic i_op(input logic [9:0] op, input logic [4:0] rd, rn, input logic [11:0] imm);
        put({op, imm, rn, rd});
        if (op == `LEGV8_OP_SUBI) write_reg(rd, regs_m[rn] - {52'h0, imm});
        else write_reg(rd, regs_m[rn] + {52'h0, imm});
    endtask

    task automatic store_off(input logic [4:0] rt, input logic [8:0] off, input bit predicted);
        logic [63:0] addr;
        addr = regs_m[XBASE] + {{55{off[8]}}, off};
        put({`LEGV8_OP_STUR, off, 2'b00, XBASE, rt});
        if (predicted) begin
            exp_addr.push_back(addr);
            exp_data.push_back(regs_m[rt]);
            mem_m[addr[10:3]] = regs_m[rt];
        end
    endtask

    // Offsets walk from -256 up in doublewords
    task automatic store(input logic [4:0] rt, input bit predicted);
        store_off(rt, 9'(-256 + 8 * (slot % 64)), predicted);
        slot++;
    endtask

    task automatic load(input logic [4:0] rt, input logic [8:0] off);
        load_addr = regs_m[XBASE] + {{55{off[8]}}, off};
        put({`LEGV8_OP_LDUR, off, 2'b00, XBASE, rt});
        write_reg(rt, mem_m[load_addr[10:3]]);
    endtask

    // Branch, not-taken marker, skip, taken marker
    task automatic cond_block(input logic [31:0] branch, input bit taken);
        put(branch);               // Offset 3 lands on the taken marker
        store(XNT, !taken);
        put({`LEGV8_OP_B, 26'd2});
        store(XT, taken);
    endtask

    task automatic eq_ne_blocks();
        cond_block({`LEGV8_OP_BCOND, 19'd3, `LEGV8_COND_EQ}, z_m);
        cond_block({`LEGV8_OP_BCOND, 19'd3, `LEGV8_COND_NE}, !z_m);
    endtask

    task automatic arith_round(input int p);
        logic [10:0] ops [5];
        logic [63:0] a, b;
        ops = '{`LEGV8_OP_ADD, `LEGV8_OP_SUB, `LEGV8_OP_AND, `LEGV8_OP_ORR, `LEGV8_OP_EOR};
        a = rand64();
        b = (p == 0) ? ~a + 64'd7 : rand64();  // First pair forces a carry out
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int i = 0; i < 5; i++) begin
            r_op(ops[i], 5'd3, 5'd1, 5'd2, 6'd0);
            store(5'd3, 1'b1);
        end
        r_op(`LEGV8_OP_LSL, 5'd3, 5'd1, 5'd31, 6'($random(seed)));
        store(5'd3, 1'b1);
        r_op(`LEGV8_OP_LSR, 5'd3, 5'd1, 5'd31, 6'($random(seed)));
        store(5'd3, 1'b1);
        i_op(`LEGV8_OP_ADDI, 5'd3, 5'd1, 12'($random(seed)));
        store(5'd3, 1'b1);
        i_op(`LEGV8_OP_SUBI, 5'd3, 5'd1, 12'($random(seed)));
        store(5'd3, 1'b1);
    endtask

    initial begin
        int          n;
        logic [63:0] a;
        logic [63:0] halt_addr;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = 32'h0;  // HALT everywhere
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]  = 64'h0;
            mem_m[i] = 64'h0;
        end
        for (int i = 0; i < 32; i++) regs_m[i] = 64'h0;
        {val_errs, other_errs, stores_seen, loads_seen, pc_w, slot} = '0;
        z_m       = 1'b0;
        wr_pend   = 1'b0;
        wr_addr   = 64'h0;
        wr_data   = 64'h0;
        load_addr = '1;

        i_op(`LEGV8_OP_ADDI, XBASE, 5'd31, 12'h400);  // Stores land at 0x300..0x4f8

        // Wide immediates, then one lane replaced
        for (int i = 0; i < 4; i++) begin
            load_const(5'd1, rand64());
            store(5'd1, 1'b1);
            movk(5'd1, 2'($random(seed)), 16'($random(seed)));
            store(5'd1, 1'b1);
        end

        for (int p = 0; p < 3; p++) arith_round(p);

        // Store, reload below the base, store again
        load_const(5'd1, rand64());
        store_off(5'd1, 9'h1f0, 1'b1);
        load(5'd4, 9'h1f0);
        store(5'd4, 1'b1);

        load_const(XT, rand64());
        load_const(XNT, rand64());
        a = rand64();
        load_const(5'd5, a);
        load_const(5'd6, a);
        load_const(5'd8, -a);           // Sums to zero with X5
        load_const(5'd9, a + 64'd1);
        r_op(`LEGV8_OP_SUBS, 5'd7, 5'd5, 5'd6, 6'd0);
        eq_ne_blocks();
        r_op(`LEGV8_OP_ADDS, 5'd7, 5'd5, 5'd8, 6'd0);
        eq_ne_blocks();
        r_op(`LEGV8_OP_SUBS, 5'd7, 5'd5, 5'd9, 6'd0);
        eq_ne_blocks();
        r_op(`LEGV8_OP_ADDS, 5'd7, 5'd5, 5'd6, 6'd0);
        eq_ne_blocks();
        cond_block({`LEGV8_OP_CBZ, 19'd3, 5'd0}, regs_m[0] == 64'h0);
        cond_block({`LEGV8_OP_CBZ, 19'd3, 5'd5}, regs_m[5] == 64'h0);

        put({`LEGV8_OP_B, 26'd2});      // Forward over one store
        store(XNT, 1'b0);
        store(XT, 1'b1);

        i_op(`LEGV8_OP_ADDI, 5'd10, 5'd31, 12'((pc_w + 3) * 4));  // Taken marker address
        put({`LEGV8_OP_BR, 5'd31, 6'd0, 5'd10, 5'd0});
        store(XNT, 1'b0);
        store(XT, 1'b1);
        halt_addr = 64'(pc_w * 4);      // Next word is already HALT

        for (n = 0; n < 50 && rst_n !== 1'b1; n++) @(negedge clk);
        assert (rst_n === 1'b1) else begin
            $display("reset was never released");
            other_errs++;
        end
        check_value("imem_addr", imem_addr, 64'h0);  // First fetch after reset
        check_value("halted", 64'(halted), 64'h0);

        for (n = 0; n < HALT_TIMEOUT && !halted; n++) @(negedge clk);
        assert (halted) else begin
            $display("timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
            other_errs++;
        end
        if (halted) begin
            for (n = 0; n < 20; n++) begin
                @(negedge clk);
                check_value("halted", 64'(halted), 64'h1);
                check_value("imem_addr", imem_addr, halt_addr);
            end
        end
        assert (exp_addr.size() == 0) else begin
            $display("%0d predicted stores never appeared", exp_addr.size());
            other_errs++;
        end
        assert (loads_seen == 1) else begin
            $display("saw %0d read strobes where one load was expected", loads_seen);
            other_errs++;
        end

        $display("%0d value errors, %0d other errors, %0d stores seen",
                 val_errs, other_errs, stores_seen);
        if (val_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- legv8_mc.f
+incdir+design
design/legv8_pkg.sv
design/wide_imm_decoder.sv
design/instr_decoder.sv
design/alu.sv
design/reg_file.sv
design/legv8_cpu.sv
tb/tb_clock.sv
tb/tb_legv8_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_legv8_cpu
FILELIST  ?= legv8_mc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
SOURCES   := design/legv8_defines.svh $(wildcard design/*.sv) $(wildcard tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
